// File: axis_sw_pkg.sv
`default_nettype none

package axis_sw_pkg;

  //////////////////////////////
  // widths and counts
  //////////////////////////////

  // stream data width, default for every data_w parameter
  localparam int DATA_W  = 32;

  // upstream sources: user project, register bridge, logic analyzer
  localparam int NUM_SRC = 3;

  //////////////////////////////
  // tags and small fields
  //////////////////////////////

  typedef logic [1:0] tid_t;

  localparam tid_t TID_UP = 2'd0;
  localparam tid_t TID_AA = 2'd1;
  localparam tid_t TID_LA = 2'd2;

  typedef logic [1:0] user_t;

  // fifo fill threshold
  typedef logic [3:0] th_t;

  localparam th_t TH_RESET = 4'd6;

  //////////////////////////////
  // stream beats
  //////////////////////////////

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
    logic [DATA_W/8-1:0] keep;
    logic                last;
    user_t               user;
  } axis_beat_t;

  // beat plus its source or destination tag
  typedef struct packed {
    axis_beat_t beat;
    tid_t       tid;
  } axis_tagged_t;

endpackage

`default_nettype wire

// File: sw_cfg_regs.sv
`default_nettype none

module sw_cfg_regs
  import axis_sw_pkg::*;
#(
  parameter int data_w = DATA_W
) (
  input  wire                  axis_clk,
  input  wire                  axi_reset_n,
  input  wire                  cfg_enable,
  // write address and data
  input  wire                  awvalid,
  input  wire [14:0]           awaddr,
  input  wire                  wvalid,
  input  wire [data_w-1:0]     wdata,
  input  wire [data_w/8-1:0]   wstrb,
  output logic                 awready,
  output logic                 wready,
  // read side, always answering
  output logic                 arready,
  output logic                 rvalid,
  output logic [data_w-1:0]    rdata,
  output th_t                  threshold
);

  logic wr_take;
  logic wr_hit;

  // address and data accepted together, only while the block is enabled
  assign wr_take = cfg_enable && awvalid && wvalid;
  assign awready = wr_take;
  assign wready  = wr_take;

  // byte address, word 0 is the only register
  assign wr_hit = wr_take && (awaddr[14:2] == '0) && wstrb[0];

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      threshold <= TH_RESET;
    end else if (wr_hit) begin
      threshold <= th_t'(wdata[$bits(th_t)-1:0]);
    end
  end

  // single register, so any read returns it
  assign arready = 1'b1;
  assign rvalid  = 1'b1;
  assign rdata   = data_w'(threshold);

endmodule

`default_nettype wire

// File: sw_arbiter.sv
`default_nettype none

module sw_arbiter
  import axis_sw_pkg::*;
#(
  parameter int data_w = DATA_W
) (
  input  wire                 axis_clk,
  input  wire                 axi_reset_n,
  input  wire [NUM_SRC-1:0]   req,
  input  wire                 frame_done,
  output logic [NUM_SRC-1:0]  grant
);

  localparam int IDX_W = $clog2(NUM_SRC);

  // beat struct layout is fixed by the package width
  if (data_w != DATA_W) begin : g_width_check
    $error("data_w differs from the package DATA_W");
  end

  logic [IDX_W-1:0]   base_q;
  logic [IDX_W-1:0]   base_nxt;
  logic [NUM_SRC-1:0] pick;

  //////////////////////////////
  // first requester from base
  //////////////////////////////

  // walk downwards so the nearest requester after base wins
  always_comb begin : find_first
    int unsigned idx;
    pick = '0;
    for (int k = NUM_SRC - 1; k >= 0; k--) begin
      idx = (int'(base_q) + k) % NUM_SRC;
      if (req[idx]) begin
        pick = '0;
        pick[idx] = 1'b1;
      end
    end
  end

  // base moves to the source after the granted one
  always_comb begin : next_base
    base_nxt = base_q;
    for (int i = 0; i < NUM_SRC; i++) begin
      if (grant[i]) begin
        base_nxt = (i == NUM_SRC - 1) ? '0 : IDX_W'(i + 1);
      end
    end
  end

  //////////////////////////////
  // grant and base registers
  //////////////////////////////

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      grant  <= '0;
      base_q <= '0;
    end else if (grant == '0) begin
      grant <= pick;
    end else if (frame_done) begin
      // one idle cycle, then the next frame is picked
      grant  <= '0;
      base_q <= base_nxt;
    end
  end

endmodule

`default_nettype wire

// File: sw_upstream_mux.sv
`default_nettype none

module sw_upstream_mux
  import axis_sw_pkg::*;
#(
  parameter int data_w = DATA_W
) (
  input  wire                              axis_clk,
  input  wire                              axi_reset_n,
  input  wire [NUM_SRC-1:0]                grant,
  input  wire axis_beat_t [NUM_SRC-1:0]    src_beat,
  input  wire [NUM_SRC-1:0]                src_valid,
  output logic [NUM_SRC-1:0]               src_ready,
  output axis_tagged_t                     out_beat,
  output logic                             out_valid,
  input  wire                              out_ready,
  output logic                             frame_done
);

  if (data_w != DATA_W) begin : g_width_check
    $error("data_w differs from the package DATA_W");
  end

  tid_t sel;
  logic can_load;
  logic take;

  // one-hot grant to source index, which is also the tid
  always_comb begin : pick_src
    sel = TID_UP;
    for (int i = 0; i < NUM_SRC; i++) begin
      if (grant[i]) begin
        sel = tid_t'(i);
      end
    end
  end

  //////////////////////////////
  // source handshake
  //////////////////////////////

  // output register free, or draining this cycle
  assign can_load   = !out_valid || out_ready;
  assign src_ready  = grant & {NUM_SRC{can_load}};
  assign take       = |(src_ready & src_valid);
  assign frame_done = take && src_beat[sel].last;

  //////////////////////////////
  // output holding register
  //////////////////////////////

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // beat is only replaced on a new transfer, so it holds under back-pressure
  always_ff @(posedge axis_clk) begin
    if (take) begin
      out_beat.beat <= src_beat[sel];
      out_beat.tid  <= sel;
    end
  end

endmodule

`default_nettype wire

// File: sw_downstream_demux.sv
`default_nettype none

module sw_downstream_demux
  import axis_sw_pkg::*;
#(
  parameter int data_w     = DATA_W,
  parameter int fifo_depth = 16
) (
  input  wire                 axis_clk,
  input  wire                 axi_reset_n,
  input  wire th_t            threshold,
  // from the serializer
  input  wire axis_tagged_t   in_beat,
  input  wire                 in_valid,
  output logic                in_ready,
  // to the user project
  output axis_beat_t          up_beat,
  output logic                up_valid,
  input  wire                 up_ready,
  // to the register bridge
  output axis_beat_t          aa_beat,
  output logic                aa_valid,
  input  wire                 aa_ready
);

  localparam int AW = $clog2(fifo_depth);

  if (data_w != DATA_W) begin : g_width_check
    $error("data_w differs from the package DATA_W");
  end

  axis_tagged_t mem [fifo_depth];
  axis_tagged_t head;

  // one extra bit tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] fill;
  logic        wr_en;
  logic        empty;
  logic        drop;
  logic        pop;

  //////////////////////////////
  // write side
  //////////////////////////////

  assign wr_en = in_valid && in_ready;
  assign fill  = wr_ptr - rd_ptr;

  always_ff @(posedge axis_clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= in_beat;
    end
  end

  // ready follows the fill level one cycle late
  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      wr_ptr   <= '0;
      in_ready <= 1'b0;
    end else begin
      in_ready <= (32'(fill) <= 32'(threshold));
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // head routing
  //////////////////////////////

  assign empty = (wr_ptr == rd_ptr);
  assign head  = mem[rd_ptr[AW-1:0]];

  always_comb begin : route_head
    up_valid = 1'b0;
    aa_valid = 1'b0;
    drop     = 1'b0;
    if (!empty) begin
      case (head.tid)
        TID_UP:  up_valid = 1'b1;
        TID_AA:  aa_valid = 1'b1;
        // no receiver for these tags
        default: drop = 1'b1;
      endcase
    end
  end

  assign up_beat = head.beat;
  assign aa_beat = head.beat;
  assign pop     = (up_valid && up_ready) || (aa_valid && aa_ready) || drop;

  always_ff @(posedge axis_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: axis_sw.sv
`default_nettype none

module axis_sw
  import axis_sw_pkg::*;
#(
  parameter int data_w     = DATA_W,
  parameter int fifo_depth = 16
) (
  input  wire                  axis_clk,
  input  wire                  axi_reset_n,
  input  wire                  cc_as_enable,
  // lite bus
  input  wire                  axi_awvalid,
  input  wire [14:0]           axi_awaddr,
  output logic                 axi_awready,
  input  wire                  axi_wvalid,
  input  wire [data_w-1:0]     axi_wdata,
  input  wire [data_w/8-1:0]   axi_wstrb,
  output logic                 axi_wready,
  output logic                 axi_arready,
  output logic                 axi_rvalid,
  output logic [data_w-1:0]    axi_rdata,
  // upstream sources
  input  wire axis_beat_t      up_as_beat,
  input  wire                  up_as_tvalid,
  output logic                 as_up_tready,
  input  wire axis_beat_t      aa_as_beat,
  input  wire                  aa_as_tvalid,
  output logic                 as_aa_tready,
  input  wire axis_beat_t      la_as_beat,
  input  wire                  la_as_tvalid,
  output logic                 as_la_tready,
  // serializer link, both directions
  output axis_tagged_t         as_is_beat,
  output logic                 as_is_tvalid,
  input  wire                  is_as_tready,
  input  wire axis_tagged_t    is_as_beat,
  input  wire                  is_as_tvalid,
  output logic                 as_is_tready,
  // downstream receivers
  output axis_beat_t           as_up_beat,
  output logic                 as_up_tvalid,
  input  wire                  up_as_tready,
  output axis_beat_t           as_aa_beat,
  output logic                 as_aa_tvalid,
  input  wire                  aa_as_tready
);

  logic [NUM_SRC-1:0]             req;
  logic [NUM_SRC-1:0]             grant;
  logic [NUM_SRC-1:0]             src_ready;
  axis_beat_t [NUM_SRC-1:0]       src_beat;
  logic                           frame_done;
  th_t                            threshold;

  // index order is the tid order
  assign req      = {la_as_tvalid, aa_as_tvalid, up_as_tvalid};
  assign src_beat = {la_as_beat, aa_as_beat, up_as_beat};

  assign as_up_tready = src_ready[TID_UP];
  assign as_aa_tready = src_ready[TID_AA];
  assign as_la_tready = src_ready[TID_LA];

  sw_cfg_regs #(.data_w(data_w)) u_cfg_regs (
    .axis_clk    (axis_clk),
    .axi_reset_n (axi_reset_n),
    .cfg_enable  (cc_as_enable),
    .awvalid     (axi_awvalid),
    .awaddr      (axi_awaddr),
    .wvalid      (axi_wvalid),
    .wdata       (axi_wdata),
    .wstrb       (axi_wstrb),
    .awready     (axi_awready),
    .wready      (axi_wready),
    .arready     (axi_arready),
    .rvalid      (axi_rvalid),
    .rdata       (axi_rdata),
    .threshold   (threshold)
  );

  sw_arbiter #(.data_w(data_w)) u_arbiter (
    .axis_clk    (axis_clk),
    .axi_reset_n (axi_reset_n),
    .req         (req),
    .frame_done  (frame_done),
    .grant       (grant)
  );

  sw_upstream_mux #(.data_w(data_w)) u_upstream_mux (
    .axis_clk    (axis_clk),
    .axi_reset_n (axi_reset_n),
    .grant       (grant),
    .src_beat    (src_beat),
    .src_valid   (req),
    .src_ready   (src_ready),
    .out_beat    (as_is_beat),
    .out_valid   (as_is_tvalid),
    .out_ready   (is_as_tready),
    .frame_done  (frame_done)
  );

  sw_downstream_demux #(
    .data_w     (data_w),
    .fifo_depth (fifo_depth)
  ) u_downstream_demux (
    .axis_clk    (axis_clk),
    .axi_reset_n (axi_reset_n),
    .threshold   (threshold),
    .in_beat     (is_as_beat),
    .in_valid    (is_as_tvalid),
    .in_ready    (as_is_tready),
    .up_beat     (as_up_beat),
    .up_valid    (as_up_tvalid),
    .up_ready    (up_as_tready),
    .aa_beat     (as_aa_beat),
    .aa_valid    (as_aa_tvalid),
    .aa_ready    (aa_as_tready)
  );

endmodule

`default_nettype wire

// File: axis_sw_sva.sv
`default_nettype none

module axis_sw_sva
  import axis_sw_pkg::*;
(
  input wire               axis_clk,
  input wire               axi_reset_n,
  input wire axis_tagged_t as_is_beat,
  input wire               as_is_tvalid,
  input wire               is_as_tready,
  input wire axis_beat_t   as_up_beat,
  input wire               as_up_tvalid,
  input wire               up_as_tready,
  input wire axis_beat_t   as_aa_beat,
  input wire               as_aa_tvalid,
  input wire               aa_as_tready,
  input wire [NUM_SRC-1:0] src_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // stream hold rules
  //////////////////////////////

  as_is_hold: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
    as_is_tvalid && !is_as_tready |=> as_is_tvalid && $stable(as_is_beat))
    else $error("as_is beat changed or vanished before the serializer took it");

  as_up_hold: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
    as_up_tvalid && !up_as_tready |=> as_up_tvalid && $stable(as_up_beat))
    else $error("as_up beat changed or vanished before the user project took it");

  as_aa_hold: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
    as_aa_tvalid && !aa_as_tready |=> as_aa_tvalid && $stable(as_aa_beat))
    else $error("as_aa beat changed or vanished before the register bridge took it");

  // only the granted source may see ready
  one_src_ready: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
    $onehot0(src_ready))
    else $error("more than one upstream source ready at once");

endmodule

bind axis_sw axis_sw_sva u_axis_sw_sva (
  .axis_clk     (axis_clk),
  .axi_reset_n  (axi_reset_n),
  .as_is_beat   (as_is_beat),
  .as_is_tvalid (as_is_tvalid),
  .is_as_tready (is_as_tready),
  .as_up_beat   (as_up_beat),
  .as_up_tvalid (as_up_tvalid),
  .up_as_tready (up_as_tready),
  .as_aa_beat   (as_aa_beat),
  .as_aa_tvalid (as_aa_tvalid),
  .aa_as_tready (aa_as_tready),
  .src_ready    ({as_la_tready, as_aa_tready, as_up_tready})
);

`default_nettype wire

// File: tb_axis_sw.sv
`default_nettype none

module tb_axis_sw
  import axis_sw_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 4000;

  logic                axis_clk;
  logic                axi_reset_n;
  logic                cc_as_enable;
  logic                axi_awvalid;
  logic [14:0]         axi_awaddr;
  logic                axi_wvalid;
  logic [DATA_W-1:0]   axi_wdata;
  logic [DATA_W/8-1:0] axi_wstrb;
  wire                 axi_awready;
  wire                 axi_wready;
  wire                 axi_arready;
  wire                 axi_rvalid;
  wire  [DATA_W-1:0]   axi_rdata;

  // upstream sources indexed by tid
  axis_beat_t          src_beat [NUM_SRC];
  logic [NUM_SRC-1:0]  src_valid;
  wire  [NUM_SRC-1:0]  src_rdy;

  axis_tagged_t        as_is_beat;
  logic                as_is_tvalid;
  logic                is_as_tready;
  axis_tagged_t        is_as_beat;
  logic                is_as_tvalid;
  logic                as_is_tready;
  axis_beat_t          as_up_beat;
  logic                as_up_tvalid;
  logic                up_as_tready;
  axis_beat_t          as_aa_beat;
  logic                as_aa_tvalid;
  logic                aa_as_tready;

  // scoreboards per destination
  axis_tagged_t        exp_is [$];
  axis_beat_t          exp_up [$];
  axis_beat_t          exp_aa [$];

  logic [31:0]         lfsr = 32'h22daf52e;
  logic                stall_on = 1'b0;
  logic                hold_rx = 1'b0;
  logic                timed_out = 1'b0;
  logic                in_test = 1'b0;
  logic [8*24-1:0]     cur_name;
  int                  rr_base = 0;
  th_t                 th_model = TH_RESET;
  int                  errors = 0;
  int                  checks = 0;
  int                  test_base = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;

  axis_sw #(
    .data_w     (DATA_W),
    .fifo_depth (16)
  ) u_axis_sw (
    .axis_clk     (axis_clk),
    .axi_reset_n  (axi_reset_n),
    .cc_as_enable (cc_as_enable),
    .axi_awvalid  (axi_awvalid),
    .axi_awaddr   (axi_awaddr),
    .axi_awready  (axi_awready),
    .axi_wvalid   (axi_wvalid),
    .axi_wdata    (axi_wdata),
    .axi_wstrb    (axi_wstrb),
    .axi_wready   (axi_wready),
    .axi_arready  (axi_arready),
    .axi_rvalid   (axi_rvalid),
    .axi_rdata    (axi_rdata),
    .up_as_beat   (src_beat[0]),
    .up_as_tvalid (src_valid[0]),
    .as_up_tready (src_rdy[0]),
    .aa_as_beat   (src_beat[1]),
    .aa_as_tvalid (src_valid[1]),
    .as_aa_tready (src_rdy[1]),
    .la_as_beat   (src_beat[2]),
    .la_as_tvalid (src_valid[2]),
    .as_la_tready (src_rdy[2]),
    .as_is_beat   (as_is_beat),
    .as_is_tvalid (as_is_tvalid),
    .is_as_tready (is_as_tready),
    .is_as_beat   (is_as_beat),
    .is_as_tvalid (is_as_tvalid),
    .as_is_tready (as_is_tready),
    .as_up_beat   (as_up_beat),
    .as_up_tvalid (as_up_tvalid),
    .up_as_tready (up_as_tready),
    .as_aa_beat   (as_aa_beat),
    .as_aa_tvalid (as_aa_tvalid),
    .aa_as_tready (aa_as_tready)
  );

  initial begin
    axis_clk = 1'b0;
    forever #50 axis_clk = ~axis_clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_rand_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  // payload words count up from the first word
  function automatic axis_beat_t make_beat(input logic [31:0] first, input int i, input int n);
    axis_beat_t b;
    b.data = first + 32'(i);
    b.strb = '1;
    b.keep = '1;
    b.last = (i == n - 1);
    b.user = user_t'(i);
    return b;
  endfunction

  function automatic logic ready_of(input int which);
    return (which < NUM_SRC) ? src_rdy[which] : as_is_tready;
  endfunction

  function automatic logic streams_busy();
    return exp_is.size() != 0 || exp_up.size() != 0 || exp_aa.size() != 0 ||
           as_is_tvalid || as_up_tvalid || as_aa_tvalid;
  endfunction

  task automatic note_timeout(input string what);
    if (!timed_out) begin
      $display("timeout at %0t ns: %0s did not complete in time", $time, what);
      errors++;
    end
    timed_out = 1'b1;
  endtask

  // returns at the drive point after the edge that takes the beat
  task automatic wait_ready(input int which, input string what);
    int waited;
    waited = 0;
    @(negedge axis_clk);
    while (!ready_of(which) && !timed_out) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        note_timeout(what);
      end else begin
        @(negedge axis_clk);
      end
    end
    @(posedge axis_clk);
    #5;
  endtask

  task automatic drain_streams();
    int waited;
    waited = 0;
    @(negedge axis_clk);
    while (streams_busy() && !timed_out) begin
      waited++;
      if (waited > DRAIN_LIMIT) begin
        note_timeout("delivery of all expected beats");
      end else begin
        @(negedge axis_clk);
      end
    end
    @(posedge axis_clk);
    #5;
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic expect_source_frame(input int src, input int n, input logic [31:0] first);
    axis_tagged_t t;
    for (int i = 0; i < n; i++) begin
      t.beat = make_beat(first, i, n);
      t.tid  = tid_t'(src);
      exp_is.push_back(t);
    end
  endtask

  task automatic drive_source_frame(input int src, input int n, input logic [31:0] first);
    for (int i = 0; i < n && !timed_out; i++) begin
      src_beat[src]  = make_beat(first, i, n);
      src_valid[src] = 1'b1;
      wait_ready(src, $sformatf("source %0d beat %0d", src, i));
    end
    src_valid[src] = 1'b0;
  endtask

  // frames leave in rotation after the last source served
  task automatic send_all_sources(input int n, input logic [31:0] first);
    int s;
    for (int k = 0; k < NUM_SRC; k++) begin
      s = (rr_base + k) % NUM_SRC;
      expect_source_frame(s, n, first + 32'(s) * 32'h100);
    end
    fork
      drive_source_frame(0, n, first);
      drive_source_frame(1, n, first + 32'h100);
      drive_source_frame(2, n, first + 32'h200);
    join
  endtask

  task automatic drive_link_frame(input int tid, input int n, input logic [31:0] first);
    axis_beat_t b;
    for (int i = 0; i < n && !timed_out; i++) begin
      b = make_beat(first, i, n);
      // tags 2 and 3 have no receiver
      if (tid == TID_UP) begin
        exp_up.push_back(b);
      end else if (tid == TID_AA) begin
        exp_aa.push_back(b);
      end
      is_as_beat.beat = b;
      is_as_beat.tid  = tid_t'(tid);
      is_as_tvalid    = 1'b1;
      wait_ready(NUM_SRC, $sformatf("serializer beat %0d", i));
    end
    is_as_tvalid = 1'b0;
  endtask

  task automatic write_reg(input logic en, input logic [14:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
    cc_as_enable = en;
    axi_awvalid  = 1'b1;
    axi_wvalid   = 1'b1;
    axi_awaddr   = addr;
    axi_wstrb    = strb;
    axi_wdata    = data;
    @(negedge axis_clk);
    checks++;
    assert (axi_awready == en && axi_wready == en) else begin
      $display("Fail at %0t ns: write ready %b/%b, expected %b", $time, axi_awready,
               axi_wready, en);
      errors++;
    end
    @(posedge axis_clk);
    #5;
    axi_awvalid  = 1'b0;
    axi_wvalid   = 1'b0;
    cc_as_enable = 1'b1;
    if (en && addr[14:2] == '0 && strb[0]) begin
      th_model = th_t'(data[3:0]);
    end
  endtask

  task automatic read_reg(input logic [31:0] expected);
    @(negedge axis_clk);
    checks++;
    assert (axi_arready && axi_rvalid && axi_rdata == expected) else begin
      $display("Fail at %0t ns: register read %h with arready %b rvalid %b, expected %h",
               $time, axi_rdata, axi_arready, axi_rvalid, expected);
      errors++;
    end
    @(posedge axis_clk);
    #5;
  endtask

  // receivers held off so the FIFO fills until its ready drops
  task automatic check_fill_level(input logic [31:0] first);
    int         held;
    axis_beat_t b;
    drain_streams();
    hold_rx = 1'b1;
    @(posedge axis_clk);
    #5;
    held = 0;
    while (!timed_out) begin
      b = make_beat(first, held, 0);
      is_as_beat.beat = b;
      is_as_beat.tid  = TID_UP;
      is_as_tvalid    = 1'b1;
      @(negedge axis_clk);
      if (!as_is_tready) begin
        break;
      end
      exp_up.push_back(b);
      held++;
      if (held > WAIT_LIMIT) begin
        note_timeout("FIFO fill with stalled receivers");
      end
      @(posedge axis_clk);
      #5;
    end
    @(posedge axis_clk);
    #5;
    is_as_tvalid = 1'b0;
    checks++;
    // ready is one cycle behind the fill level so two beats land past the threshold
    assert (held == int'(th_model) + 2) else begin
      $display("Fail at %0t ns: FIFO took %0d beats before ready fell, expected %0d",
               $time, held, int'(th_model) + 2);
      errors++;
    end
    hold_rx = 1'b0;
  endtask

  task automatic close_test();
    int n;
    drain_streams();
    n = errors - test_base;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
    end
    $display("test %0s: %0s, %0d errors", cur_name, (n == 0) ? "ok" : "FAILED", n);
  endtask

  //////////////////////////////
  // readies and monitors
  //////////////////////////////

  always @(posedge axis_clk) begin : ready_drive
    logic b0;
    logic b1;
    logic b2;
    #5;
    if (stall_on) begin
      next_rand_bit(b0);
      next_rand_bit(b1);
      next_rand_bit(b2);
    end else begin
      b0 = 1'b1;
      b1 = 1'b1;
      b2 = 1'b1;
    end
    is_as_tready = b0;
    up_as_tready = b1 && !hold_rx;
    aa_as_tready = b2 && !hold_rx;
  end

  task automatic check_down(input int which, input axis_beat_t got);
    axis_beat_t expected;
    int         pending;
    pending = (which == 0) ? exp_up.size() : exp_aa.size();
    checks++;
    assert (pending > 0) else begin
      $display("%0s delivered a beat at %0t ns that was never sent to it",
               (which == 0) ? "as_up" : "as_aa", $time);
      errors++;
    end
    if (pending > 0) begin
      if (which == 0) begin
        expected = exp_up.pop_front();
      end else begin
        expected = exp_aa.pop_front();
      end
      checks++;
      assert (got == expected) else begin
        $display("Fail at %0t ns: %0s data %h last %b, expected data %h last %b", $time,
                 (which == 0) ? "as_up" : "as_aa", got.data, got.last, expected.data,
                 expected.last);
        errors++;
      end
    end
  endtask

  // a beat seen with valid and ready here moves on the next rising edge
  always @(negedge axis_clk) begin : out_monitor
    axis_tagged_t expected;
    if (axi_reset_n && as_is_tvalid && is_as_tready) begin
      checks++;
      assert (exp_is.size() > 0) else begin
        $display("as_is sent a beat at %0t ns that no source frame produced", $time);
        errors++;
      end
      if (exp_is.size() > 0) begin
        expected = exp_is.pop_front();
        checks++;
        assert (as_is_beat == expected) else begin
          $display("Fail at %0t ns: as_is data %h tid %0d last %b, expected %h tid %0d last %b",
                   $time, as_is_beat.beat.data, as_is_beat.tid, as_is_beat.beat.last,
                   expected.beat.data, expected.tid, expected.beat.last);
          errors++;
        end
      end
    end
    if (axi_reset_n && as_up_tvalid && up_as_tready) begin
      check_down(0, as_up_beat);
    end
    if (axi_reset_n && as_aa_tvalid && aa_as_tready) begin
      check_down(1, as_aa_beat);
    end
  end

  //////////////////////////////
  // main flow
  //////////////////////////////

  initial begin : main_flow
    int         fd;
    int         rc;
    int         a;
    int         b;
    int         c;
    int         d;
    logic [7:0] op;
    string      line;
    axi_reset_n  = 1'b0;
    cc_as_enable = 1'b1;
    axi_awvalid  = 1'b0;
    axi_awaddr   = '0;
    axi_wvalid   = 1'b0;
    axi_wdata    = '0;
    axi_wstrb    = '0;
    src_valid    = '0;
    is_as_beat   = '0;
    is_as_tvalid = 1'b0;
    is_as_tready = 1'b0;
    up_as_tready = 1'b0;
    aa_as_tready = 1'b0;
    for (int i = 0; i < NUM_SRC; i++) begin
      src_beat[i] = '0;
    end
    repeat (8) @(posedge axis_clk);
    #5;
    axi_reset_n = 1'b1;
    @(posedge axis_clk);
    #5;

    fd = $fopen("axis_sw_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file axis_sw_cases.txt");
      errors++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        rc = $sscanf(line, "%c", op);
        case (op)
          "T": begin
            if (in_test) begin
              close_test();
            end
            rc        = $sscanf(line, "%c %s %d", op, cur_name, a);
            stall_on  = (a != 0);
            in_test   = 1'b1;
            test_base = errors;
          end
          "S": begin
            rc = $sscanf(line, "%c %d %d %h", op, a, b, c);
            expect_source_frame(a, b, c);
            drive_source_frame(a, b, c);
            rr_base = (a + 1) % NUM_SRC;
          end
          "A": begin
            rc = $sscanf(line, "%c %d %h", op, b, c);
            send_all_sources(b, c);
          end
          "D": begin
            rc = $sscanf(line, "%c %d %d %h", op, a, b, c);
            drive_link_frame(a, b, c);
          end
          "W": begin
            rc = $sscanf(line, "%c %d %h %h %h", op, a, b, c, d);
            write_reg(a != 0, b[14:0], c[3:0], d);
          end
          "R": begin
            rc = $sscanf(line, "%c %h", op, b);
            read_reg(b);
          end
          "H": begin
            rc = $sscanf(line, "%c %h", op, c);
            check_fill_level(c);
          end
          default: begin
            $display("unknown record in the case file: %0s", line);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    if (in_test) begin
      close_test();
    end

    $display("%0d tests run, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: axis_sw_cases.txt
# T name stall | S src beats first_hex | A beats first_hex | D tid beats first_hex
# W enable addr_hex strb_hex data_hex | R expected_hex | H first_hex (fill with receivers held)
T single_source 0
S 0 4 00001000
S 1 3 00002000
S 2 5 00003000
T round_robin 0
A 3 00004000
S 1 2 00005000
A 2 00006000
T down_route 0
D 0 4 00007000
D 1 3 00008000
D 2 2 00009000
D 0 1 0000a000
T cfg_reg 0
R 6
W 1 0 1 3
R 3
W 0 0 1 9
R 3
W 1 4 1 9
R 3
T random_stall 1
A 4 0000b000
D 1 5 0000c000
D 2 3 0000d000
D 0 6 0000e000
S 2 3 0000f000
H 00010000

// File: vlog.f
axis_sw_pkg.sv
sw_cfg_regs.sv
sw_arbiter.sv
sw_upstream_mux.sv
sw_downstream_demux.sv
axis_sw.sv
axis_sw_sva.sv
tb_axis_sw.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the result
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axis_sw \
    -f vlog.f -o sim_axis_sw > build.log 2>&1 \
  && ./obj_dir/sim_axis_sw > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation stopped with an error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
